// ==== common/lsu_pkg.sv ====
`default_nettype none

package lsu_pkg;

    localparam int xlen      = 32;
    localparam int ram_words = 256;
    localparam int ram_aw    = 8;

    // control word type field
    localparam logic [3:0] op_mem    = 4'd5;
    localparam logic [3:0] op_atomic = 4'd6;

    // subtypes under op_mem
    localparam logic [4:0] sub_ld_b  = 5'd0;
    localparam logic [4:0] sub_ld_h  = 5'd1;
    localparam logic [4:0] sub_ld_w  = 5'd2;
    localparam logic [4:0] sub_st_b  = 5'd3;
    localparam logic [4:0] sub_st_h  = 5'd4;
    localparam logic [4:0] sub_st_w  = 5'd5;
    localparam logic [4:0] sub_ld_bu = 5'd6;
    localparam logic [4:0] sub_ld_hu = 5'd7;
    localparam logic [4:0] sub_ibar  = 5'd8;

    // subtypes under op_atomic
    localparam logic [4:0] sub_ll = 5'd0;
    localparam logic [4:0] sub_sc = 5'd1;

    typedef struct packed {
        logic [19:0] rsvd_hi;
        logic [4:0]  subtype;   // bits 11..7
        logic [2:0]  rsvd_lo;
        logic [3:0]  typ;       // bits 3..0
    } ctrl_fields_t;

    typedef union packed {
        logic [31:0]  raw;
        ctrl_fields_t f;
    } ctrl_word_u;

    // shape of the value returned to the pipeline
    typedef enum logic [2:0] {
        lk_byte_s = 3'd0,
        lk_byte_u = 3'd1,
        lk_half_s = 3'd2,
        lk_half_u = 3'd3,
        lk_word   = 3'd4,
        lk_sc     = 3'd5,
        lk_none   = 3'd6
    } load_kind_e;

endpackage

`default_nettype wire

// ==== common/mem_bus_if.sv ====
`timescale 1ns/10ps
`default_nettype none

interface mem_bus_if
    import lsu_pkg::*;
();
    logic              req;
    logic              we;
    logic [ram_aw-1:0] addr;    // word address
    logic [xlen-1:0]   wdata;
    logic [3:0]        wstrb;
    logic [xlen-1:0]   rdata;   // valid the cycle after a read

    modport requester (
        output req, we, addr, wdata, wstrb,
        input  rdata
    );

    modport memory (
        input  req, we, addr, wdata, wstrb,
        output rdata
    );

endinterface

`default_nettype wire

// ==== lsu/mem_req_decode.sv ====
`timescale 1ns/10ps
`default_nettype none

module mem_req_decode
    import lsu_pkg::*;
(
    input  logic [xlen-1:0] rj,
    input  logic [xlen-1:0] imm,
    input  ctrl_word_u      ctrl,
    input  logic [xlen-1:0] rd_data,
    input  logic            ex_valid,
    mem_bus_if.requester    bus,
    output logic            is_ll,
    output logic            is_sc,
    output load_kind_e      load_kind,
    output logic [1:0]      byte_off,
    output logic            ale,
    output logic            op_valid
);

    logic [xlen-1:0] addr;
    logic [1:0]      size;      // 0 byte, 1 half, 2 word
    logic            access;
    logic            wr;
    logic            misalign;
    logic [3:0]      strb;
    logic [xlen-1:0] lane_data;

    assign addr     = rj + imm;
    assign byte_off = addr[1:0];

    always_comb
    begin
        op_valid  = 1'b0;
        access    = 1'b0;
        wr        = 1'b0;
        size      = 2'd2;
        is_ll     = 1'b0;
        is_sc     = 1'b0;
        load_kind = lk_none;
        if (ex_valid)
        begin
            if (ctrl.f.typ == op_mem)
            begin
                op_valid = 1'b1;
                access   = 1'b1;
                case (ctrl.f.subtype)
                    sub_ld_b:  begin size = 2'd0; load_kind = lk_byte_s; end
                    sub_ld_h:  begin size = 2'd1; load_kind = lk_half_s; end
                    sub_ld_w:  load_kind = lk_word;
                    sub_st_b:  begin size = 2'd0; wr = 1'b1; end
                    sub_st_h:  begin size = 2'd1; wr = 1'b1; end
                    sub_st_w:  wr = 1'b1;
                    sub_ld_bu: begin size = 2'd0; load_kind = lk_byte_u; end
                    sub_ld_hu: begin size = 2'd1; load_kind = lk_half_u; end
                    sub_ibar:  access = 1'b0;                 // no-op, no cache here
                    default:
                    begin
                        op_valid = 1'b0;
                        access   = 1'b0;
                    end
                endcase
            end
            else if (ctrl.f.typ == op_atomic)
            begin
                case (ctrl.f.subtype)
                    sub_ll:
                    begin
                        op_valid  = 1'b1;
                        access    = 1'b1;
                        is_ll     = 1'b1;
                        load_kind = lk_word;
                    end
                    sub_sc:
                    begin
                        op_valid  = 1'b1;
                        access    = 1'b1;
                        wr        = 1'b1;
                        is_sc     = 1'b1;
                        load_kind = lk_sc;
                    end
                    default: ;
                endcase
            end
        end
    end

    // little endian lanes, data replicated so strobes pick the lane
    always_comb
    begin
        case (size)
            2'd0:
            begin
                misalign  = 1'b0;
                strb      = 4'b0001 << byte_off;
                lane_data = {4{rd_data[7:0]}};
            end
            2'd1:
            begin
                misalign  = byte_off[0];
                strb      = 4'b0011 << byte_off;
                lane_data = {2{rd_data[15:0]}};
            end
            default:
            begin
                misalign  = |byte_off;
                strb      = 4'b1111;
                lane_data = rd_data;
            end
        endcase
    end

    assign ale       = access & misalign;
    assign bus.req   = access & ~misalign;     // misaligned never reaches ram
    assign bus.we    = wr;
    assign bus.addr  = addr[ram_aw+1:2];
    assign bus.wdata = lane_data;
    assign bus.wstrb = strb;

endmodule

`default_nettype wire

// ==== lsu/ll_bit_ctrl.sv ====
`timescale 1ns/10ps
`default_nettype none

module ll_bit_ctrl
    import lsu_pkg::*;
(
    input  logic              clk,
    input  logic              arst_n,
    mem_bus_if.memory         up,
    input  logic              is_ll,
    input  logic              is_sc,
    input  logic              ext_wr,     // granted external write
    input  logic [ram_aw-1:0] ext_addr,
    mem_bus_if.requester      down,
    output logic              sc_ok
);

    logic              ll_bit;
    logic [ram_aw-1:0] ll_addr;

    assign sc_ok = is_sc & up.req & ll_bit & (ll_addr == up.addr);

    assign down.req   = up.req;
    assign down.we    = up.we & ~(is_sc & ~sc_ok);   // failed sc.w becomes a read
    assign down.addr  = up.addr;
    assign down.wdata = up.wdata;
    assign down.wstrb = up.wstrb;
    assign up.rdata   = down.rdata;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            ll_bit <= 1'b0;
        else if (is_sc)
            ll_bit <= 1'b0;                           // cleared by any sc.w
        else if (is_ll && up.req)
            ll_bit <= 1'b1;
        else if (ext_wr && ext_addr == ll_addr)
            ll_bit <= 1'b0;                           // another agent wrote the word
    end

    always_ff @(posedge clk)
    begin
        if (is_ll && up.req)
            ll_addr <= up.addr;
    end

endmodule

`default_nettype wire

// ==== lsu/load_align.sv ====
`timescale 1ns/10ps
`default_nettype none

module load_align
    import lsu_pkg::*;
(
    input  logic            clk,
    input  logic            arst_n,
    input  logic            op_valid,
    input  load_kind_e      load_kind,
    input  logic [1:0]      byte_off,
    input  logic            sc_ok,
    input  logic [xlen-1:0] rdata,
    output logic            mem_done,
    output logic [xlen-1:0] mem_rdata
);

    logic       done_q;
    load_kind_e kind_q;
    logic [1:0] off_q;
    logic       sc_q;
    logic [7:0]  sel_b;
    logic [15:0] sel_h;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            done_q <= 1'b0;
            kind_q <= lk_none;
        end
        else
        begin
            done_q <= op_valid;
            kind_q <= load_kind;
        end
    end

    always_ff @(posedge clk)
    begin
        off_q <= byte_off;
        sc_q  <= sc_ok;
    end

    assign sel_b = rdata[8*off_q +: 8];
    assign sel_h = off_q[1] ? rdata[31:16] : rdata[15:0];

    always_comb
    begin
        case (kind_q)
            lk_byte_s: mem_rdata = {{24{sel_b[7]}}, sel_b};
            lk_byte_u: mem_rdata = {24'b0, sel_b};
            lk_half_s: mem_rdata = {{16{sel_h[15]}}, sel_h};
            lk_half_u: mem_rdata = {16'b0, sel_h};
            lk_word:   mem_rdata = rdata;
            lk_sc:     mem_rdata = {31'b0, sc_q};
            default:   mem_rdata = '0;                  // stores and ibar
        endcase
    end

    assign mem_done = done_q;

endmodule

`default_nettype wire

// ==== logic/mem_arbiter.sv ====
`timescale 1ns/10ps
`default_nettype none

module mem_arbiter
    import lsu_pkg::*;
(
    input  logic         clk,
    input  logic         arst_n,
    mem_bus_if.memory    pipe,
    mem_bus_if.memory    ext,
    mem_bus_if.requester ram,
    output logic         ext_gnt,
    output logic         ext_rvalid
);

    logic ext_sel;
    logic ext_rd_q;

    // pipeline always wins, it cannot be stalled
    assign ext_sel = ext.req & ~pipe.req;

    assign ram.req = pipe.req | ext_sel;

    always_comb
    begin
        if (ext_sel)
        begin
            ram.we    = ext.we;
            ram.addr  = ext.addr;
            ram.wdata = ext.wdata;
            ram.wstrb = ext.wstrb;
        end
        else
        begin
            ram.we    = pipe.we;
            ram.addr  = pipe.addr;
            ram.wdata = pipe.wdata;
            ram.wstrb = pipe.wstrb;
        end
    end

    assign pipe.rdata = ram.rdata;
    assign ext.rdata  = ram.rdata;

    assign ext_gnt = ext_sel;   // pulse, requester drops req after it

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            ext_rd_q <= 1'b0;
        else
            ext_rd_q <= ext_sel & ~ext.we;
    end

    assign ext_rvalid = ext_rd_q;

endmodule

`default_nettype wire

// ==== logic/data_ram.sv ====
`timescale 1ns/10ps
`default_nettype none

module data_ram
    import lsu_pkg::*;
(
    input  logic      clk,
    mem_bus_if.memory bus
);

    logic [xlen-1:0] mem [ram_words];
    logic [xlen-1:0] rdata_q;

    always_ff @(posedge clk)
    begin
        if (bus.req)
        begin
            if (bus.we)
            begin
                for (int i = 0; i < 4; i++)
                begin
                    if (bus.wstrb[i])
                        mem[bus.addr][8*i +: 8] <= bus.wdata[8*i +: 8];
                end
            end
            rdata_q <= mem[bus.addr];   // old word on a write
        end
    end

    assign bus.rdata = rdata_q;

endmodule

`default_nettype wire

// ==== logic/mem_subsys_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module mem_subsys_top
    import lsu_pkg::*;
(
    input  logic              clk,
    input  logic              arst_n,
    input  logic              ex_valid,
    input  logic [xlen-1:0]   rj,
    input  logic [xlen-1:0]   imm,
    input  logic [xlen-1:0]   ctrl,
    input  logic [xlen-1:0]   rd_data,
    input  logic              ext_req,
    input  logic              ext_we,
    input  logic [ram_aw-1:0] ext_addr,
    input  logic [xlen-1:0]   ext_wdata,
    input  logic [3:0]        ext_wstrb,
    output logic              ale,
    output logic              mem_done,
    output logic [xlen-1:0]   mem_rdata,
    output logic              ext_gnt,
    output logic              ext_rvalid,
    output logic [xlen-1:0]   ext_rdata
);

    ctrl_word_u ctrl_u;
    logic       is_ll;
    logic       is_sc;
    logic       sc_ok;
    logic       op_valid;
    load_kind_e load_kind;
    logic [1:0] byte_off;

    mem_bus_if dec_bus ();
    mem_bus_if pipe_bus ();
    mem_bus_if ext_bus ();
    mem_bus_if ram_bus ();

    assign ctrl_u.raw = ctrl;

    assign ext_bus.req   = ext_req;
    assign ext_bus.we    = ext_we;
    assign ext_bus.addr  = ext_addr;
    assign ext_bus.wdata = ext_wdata;
    assign ext_bus.wstrb = ext_wstrb;
    assign ext_rdata     = ext_bus.rdata;

    mem_req_decode u_decode (
        .rj        (rj),
        .imm       (imm),
        .ctrl      (ctrl_u),
        .rd_data   (rd_data),
        .ex_valid  (ex_valid),
        .bus       (dec_bus.requester),
        .is_ll     (is_ll),
        .is_sc     (is_sc),
        .load_kind (load_kind),
        .byte_off  (byte_off),
        .ale       (ale),
        .op_valid  (op_valid)
    );

    ll_bit_ctrl u_ll (
        .clk      (clk),
        .arst_n   (arst_n),
        .up       (dec_bus.memory),
        .is_ll    (is_ll),
        .is_sc    (is_sc),
        .ext_wr   (ext_gnt & ext_we),
        .ext_addr (ext_addr),
        .down     (pipe_bus.requester),
        .sc_ok    (sc_ok)
    );

    mem_arbiter u_arb (
        .clk        (clk),
        .arst_n     (arst_n),
        .pipe       (pipe_bus.memory),
        .ext        (ext_bus.memory),
        .ram        (ram_bus.requester),
        .ext_gnt    (ext_gnt),
        .ext_rvalid (ext_rvalid)
    );

    data_ram u_ram (
        .clk (clk),
        .bus (ram_bus.memory)
    );

    load_align u_align (
        .clk       (clk),
        .arst_n    (arst_n),
        .op_valid  (op_valid),
        .load_kind (load_kind),
        .byte_off  (byte_off),
        .sc_ok     (sc_ok),
        .rdata     (dec_bus.rdata),
        .mem_done  (mem_done),
        .mem_rdata (mem_rdata)
    );

endmodule

`default_nettype wire

// ==== sim/mem_subsys_assert.sv ====
`timescale 1ns/10ps
`default_nettype none

module mem_subsys_assert (
    input logic clk,
    input logic arst_n,
    input logic pipe_req,
    input logic ext_we,
    input logic ext_gnt,
    input logic ext_rvalid,
    input logic is_sc,
    input logic ll_bit
);

    int fail_count = 0;

    gnt_excl: assert property (@(posedge clk) disable iff (!arst_n)
        ext_gnt |-> !pipe_req)
    else
    begin
        $error("ext_gnt given while the pipeline requested the RAM");
        fail_count++;
    end

    rvalid_src: assert property (@(posedge clk) disable iff (!arst_n)
        ext_rvalid |-> $past(ext_gnt && !ext_we))
    else
    begin
        $error("ext_rvalid without a preceding read grant");
        fail_count++;
    end

    sc_clears: assert property (@(posedge clk) disable iff (!arst_n)
        is_sc |=> !ll_bit)
    else
    begin
        $error("ll bit still set after sc.w");
        fail_count++;
    end

endmodule

// unused checks tied off per target
bind mem_arbiter mem_subsys_assert arb_chk (
    .clk        (clk),
    .arst_n     (arst_n),
    .pipe_req   (pipe.req),
    .ext_we     (ext.we),
    .ext_gnt    (ext_gnt),
    .ext_rvalid (ext_rvalid),
    .is_sc      (1'b0),
    .ll_bit     (1'b0)
);

bind ll_bit_ctrl mem_subsys_assert ll_chk (
    .clk        (clk),
    .arst_n     (arst_n),
    .pipe_req   (1'b0),
    .ext_we     (1'b0),
    .ext_gnt    (1'b0),
    .ext_rvalid (1'b0),
    .is_sc      (is_sc),
    .ll_bit     (ll_bit)
);

`default_nettype wire

// ==== sim/mem_subsys_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module mem_subsys_tb
    import lsu_pkg::*;
();

    logic              clk;
    logic              arst_n;
    logic              ex_valid;
    logic [xlen-1:0]   rj;
    logic [xlen-1:0]   imm;
    logic [xlen-1:0]   ctrl;
    logic [xlen-1:0]   rd_data;
    logic              ext_req;
    logic              ext_we;
    logic [ram_aw-1:0] ext_addr;
    logic [xlen-1:0]   ext_wdata;
    logic [3:0]        ext_wstrb;
    logic              ale;
    logic              mem_done;
    logic [xlen-1:0]   mem_rdata;
    logic              ext_gnt;
    logic              ext_rvalid;
    logic [xlen-1:0]   ext_rdata;

    integer            seed;
    string             test_name;
    logic [xlen-1:0]   shadow [ram_words];   // model of the RAM
    logic              ll_bit;
    logic [ram_aw-1:0] ll_addr;
    logic              pend;                 // pipeline result due at next falling edge
    logic              pend_chk;
    logic [xlen-1:0]   pend_data;
    int                last_wait;
    int                i;
    int                j;
    int                asrt_fails;
    logic [4:0]        sub;
    logic [9:0]        ba;
    logic [ram_aw-1:0] w;
    logic [xlen-1:0]   r;
    logic [xlen-1:0]   d;
    logic [4:0]        st_subs [3] = '{sub_st_b, sub_st_h, sub_st_w};
    logic [4:0]        ld_subs [5] = '{sub_ld_b, sub_ld_h, sub_ld_w, sub_ld_bu, sub_ld_hu};
    logic [4:0]        mis_subs [4] = '{sub_ld_h, sub_st_h, sub_ld_w, sub_st_w};

    mem_subsys_top UUT (.*);

    task automatic check(input string what, input logic [xlen-1:0] exp,
        input logic [xlen-1:0] act);
        if (exp !== act)
        begin
            $display("CHECK FAILED %s %s expected %h actual %h", test_name, what, exp, act);
            $display("FAIL: see errors above");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    task automatic report_timeout(input string what);
        $display("TIMEOUT in %s: %s", test_name, what);
        $display("FAIL: see errors above");
        $fatal(1, "stopped on a timeout");
    endtask

    function automatic logic [xlen-1:0] merge_bytes(input logic [xlen-1:0] old,
        input logic [xlen-1:0] nw, input logic [3:0] strb);
        logic [xlen-1:0] m;
        int              k;
        m = old;
        for (k = 0; k < 4; k++)
            if (strb[k])
                m[8*k +: 8] = nw[8*k +: 8];
        return m;
    endfunction

    function automatic logic [xlen-1:0] load_value(input logic [xlen-1:0] word,
        input logic [1:0] off, input logic [4:0] s);
        logic [7:0]  b;
        logic [15:0] h;
        b = word[8*off +: 8];
        h = off[1] ? word[31:16] : word[15:0];
        case (s)
            sub_ld_b:  return {{24{b[7]}}, b};
            sub_ld_bu: return {24'b0, b};
            sub_ld_h:  return {{16{h[15]}}, h};
            sub_ld_hu: return {16'b0, h};
            default:   return word;
        endcase
    endfunction

    function automatic logic [9:0] aligned_addr(input logic [4:0] s);
        logic [xlen-1:0] v;
        logic [9:0]      a;
        v = $random(seed);
        a = v[9:0];
        if (s == sub_ld_h || s == sub_ld_hu || s == sub_st_h)
            a[0] = 1'b0;
        else if (s == sub_ld_w || s == sub_st_w)
            a[1:0] = 2'b00;
        return a;
    endfunction

    task automatic result_check();
        check("mem_done", 1, 32'(mem_done));
        if (pend_chk)
            check("mem_rdata", pend_data, mem_rdata);
        pend = 1'b0;
    endtask

    // one strobe with its result predicted from the shadow RAM and ll state
    task automatic pipe_op(input logic [3:0] typ, input logic [4:0] s,
        input logic [9:0] a, input logic [xlen-1:0] sd);
        logic [ram_aw-1:0] wa;
        logic [1:0]        off;
        logic [xlen-1:0]   c;
        logic [xlen-1:0]   ofs;
        logic              mis;
        @(negedge clk);
        if (pend)
            result_check();
        else
            check("mem_done idle", 0, 32'(mem_done));
        wa  = a[9:2];
        off = a[1:0];
        if (typ == op_atomic)
            mis = off != 2'b00;
        else if (s == sub_ld_h || s == sub_ld_hu || s == sub_st_h)
            mis = off[0];
        else if (s == sub_ld_w || s == sub_st_w)
            mis = off != 2'b00;
        else
            mis = 1'b0;
        pend_data = '0;
        if (typ == op_atomic && s == sub_sc)
        begin
            pend_data[0] = !mis && ll_bit && ll_addr == wa;
            if (pend_data[0])
                shadow[wa] = sd;
            ll_bit = 1'b0;
        end
        else if (!mis && typ == op_atomic)
        begin
            pend_data = shadow[wa];
            ll_bit    = 1'b1;
            ll_addr   = wa;
        end
        else if (!mis)
        begin
            case (s)
                sub_st_b: shadow[wa][8*off +: 8] = sd[7:0];
                sub_st_h: shadow[wa][8*off +: 16] = sd[15:0];
                sub_st_w: shadow[wa] = sd;
                sub_ibar: ;
                default:  pend_data = load_value(shadow[wa], off, s);
            endcase
        end
        c        = $random(seed);   // reserved bits stay random
        c[11:7]  = s;
        c[3:0]   = typ;
        ofs      = $random(seed);
        ctrl     = c;
        imm      = {20'b0, ofs[11:0]};
        rj       = {22'b0, a} - imm;
        rd_data  = sd;
        ex_valid = 1'b1;
        pend     = 1'b1;
        pend_chk = !mis;
        #1;
        check("ale", 32'(mis), 32'(ale));
    endtask

    task automatic pipe_drain();
        int n;
        @(negedge clk);
        ex_valid = 1'b0;
        n = 0;
        while (!mem_done)
        begin
            @(negedge clk);
            n++;
            if (n > 8)
                report_timeout("mem_done did not pulse after an operation");
        end
        check("mem_done latency", 0, n);
        result_check();
    endtask

    task automatic do_op(input logic [3:0] typ, input logic [4:0] s,
        input logic [9:0] a, input logic [xlen-1:0] sd);
        pipe_op(typ, s, a, sd);
        pipe_drain();
    endtask

    task automatic ext_access(input logic we, input logic [ram_aw-1:0] a,
        input logic [xlen-1:0] wd, input logic [3:0] strb);
        int              n;
        logic [xlen-1:0] exp;
        @(negedge clk);
        ext_req   = 1'b1;
        ext_we    = we;
        ext_addr  = a;
        ext_wdata = wd;
        ext_wstrb = strb;
        n = 0;
        #1;
        while (!ext_gnt)
        begin
            @(negedge clk);
            #1;
            n++;
            if (n > 50)
                report_timeout("ext_gnt never arrived for a held request");
        end
        last_wait = n;
        exp = shadow[a];   // ram returns the word before a write
        if (we)
        begin
            shadow[a] = merge_bytes(shadow[a], wd, strb);
            if (a == ll_addr)
                ll_bit = 1'b0;
        end
        @(negedge clk);
        ext_req = 1'b0;
        n = 0;
        while (!we && !ext_rvalid)
        begin
            @(negedge clk);
            n++;
            if (n > 8)
                report_timeout("ext_rvalid did not follow a read grant");
        end
        if (!we)
            check("ext_rdata", exp, ext_rdata);
    endtask

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial
    begin
        seed      = 32'he760f1f8;
        test_name = "reset";
        arst_n    = 1'b0;
        ex_valid  = 1'b0;
        rj        = '0;
        imm       = '0;
        ctrl      = '0;
        rd_data   = '0;
        ext_req   = 1'b0;
        ext_we    = 1'b0;
        ext_addr  = '0;
        ext_wdata = '0;
        ext_wstrb = '0;
        ll_bit    = 1'b0;
        pend      = 1'b0;
        pend_chk  = 1'b0;
        pend_data = '0;
        last_wait = 0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        check("mem_done", 0, 32'(mem_done));
        check("ext_rvalid", 0, 32'(ext_rvalid));

        test_name = "init";
        for (i = 0; i < ram_words; i++)
            ext_access(1'b1, 8'(i), $random(seed), 4'hf);

        test_name = "store_load";
        for (i = 0; i < 60; i++)
        begin
            sub = st_subs[{$random(seed)} % 3];
            pipe_op(op_mem, sub, aligned_addr(sub), $random(seed));
        end
        for (i = 0; i < 60; i++)
        begin
            sub = ld_subs[{$random(seed)} % 5];
            pipe_op(op_mem, sub, aligned_addr(sub), $random(seed));
            if ({$random(seed)} % 4 == 0)
                pipe_drain();
        end
        if (pend)
            pipe_drain();

        test_name = "misalign";
        for (i = 0; i < 16; i++)
        begin
            sub = mis_subs[{$random(seed)} % 4];
            r   = $random(seed);
            ba  = r[9:0];
            if (sub == sub_ld_h || sub == sub_st_h)
                ba[0] = 1'b1;
            else if (ba[1:0] == 2'b00)
                ba[1:0] = 2'b10;
            do_op(op_mem, sub, ba, $random(seed));
            do_op(op_mem, sub_ld_w, {ba[9:2], 2'b00}, '0);   // word untouched
        end

        test_name = "ll_sc";
        r = $random(seed);
        w = r[7:0];
        do_op(op_atomic, sub_ll, {w, 2'b00}, '0);
        do_op(op_atomic, sub_sc, {w, 2'b00}, $random(seed));
        check("first sc", 1, mem_rdata);
        do_op(op_mem, sub_ld_w, {w, 2'b00}, '0);
        do_op(op_atomic, sub_sc, {w, 2'b00}, $random(seed));
        check("second sc", 0, mem_rdata);
        do_op(op_mem, sub_ld_w, {w, 2'b00}, '0);
        pipe_op(op_atomic, sub_ll, {w, 2'b00}, '0);
        pipe_op(op_atomic, sub_sc, {w + 8'd1, 2'b00}, $random(seed));
        pipe_drain();
        check("sc other word", 0, mem_rdata);
        do_op(op_mem, sub_ld_w, {w + 8'd1, 2'b00}, '0);
        pipe_op(op_atomic, sub_ll, {w, 2'b00}, '0);
        pipe_op(op_atomic, sub_sc, {w, 2'b00}, $random(seed));
        pipe_drain();

        test_name = "ext_port";
        for (i = 0; i < 40; i++)
        begin
            r = $random(seed);
            ext_access(r[0], r[15:8], $random(seed), r[19:16]);
        end
        r = $random(seed);
        w = r[7:0];
        do_op(op_atomic, sub_ll, {w, 2'b00}, '0);
        ext_access(1'b1, w, $random(seed), 4'b0110);
        do_op(op_atomic, sub_sc, {w, 2'b00}, $random(seed));
        check("sc after ext write", 0, mem_rdata);
        do_op(op_mem, sub_ld_w, {w, 2'b00}, '0);

        test_name = "contention";
        r = $random(seed);
        w = r[7:0];
        d = $random(seed);
        fork
            ext_access(1'b1, w, d, 4'hf);
            begin
                for (j = 0; j < 6; j++)
                begin
                    sub = ld_subs[{$random(seed)} % 5];
                    ba  = aligned_addr(sub);
                    pipe_op(op_mem, sub, {w, ba[1:0]}, '0);
                end
                pipe_drain();
            end
        join
        check("ext_gnt wait", 6, last_wait);   // granted only once strobes stop
        do_op(op_mem, sub_ld_w, {w, 2'b00}, '0);

        test_name = "ibar";
        r = $random(seed);
        w = r[7:0];
        do_op(op_atomic, sub_ll, {w, 2'b00}, '0);
        do_op(op_mem, sub_ibar, {w, r[21:20]}, $random(seed));
        do_op(op_mem, sub_ld_w, {w, 2'b00}, '0);
        do_op(op_atomic, sub_sc, {w, 2'b00}, $random(seed));
        check("sc after ibar", 1, mem_rdata);

        test_name = "end";
        repeat (4) @(negedge clk);
        asrt_fails = UUT.u_arb.arb_chk.fail_count + UUT.u_ll.ll_chk.fail_count;
        if (asrt_fails == 0)
        begin
            $display("PASS: all tests");
            $finish;
        end
        else
        begin
            $display("%0d bound assertion failures", asrt_fails);
            $display("FAIL: see errors above");
            $fatal(1, "bound assertions failed");
        end
    end

endmodule

`default_nettype wire

// ==== mem_subsys.f ====
common/lsu_pkg.sv
common/mem_bus_if.sv
lsu/mem_req_decode.sv
lsu/ll_bit_ctrl.sv
lsu/load_align.sv
logic/mem_arbiter.sv
logic/data_ram.sv
logic/mem_subsys_top.sv
sim/mem_subsys_assert.sv
sim/mem_subsys_tb.sv

// ==== Bender.yml ====
package:
  name: mem_subsys

sources:
  - files:
      - common/lsu_pkg.sv
      - common/mem_bus_if.sv
      - lsu/mem_req_decode.sv
      - lsu/ll_bit_ctrl.sv
      - lsu/load_align.sv
      - logic/mem_arbiter.sv
      - logic/data_ram.sv
      - logic/mem_subsys_top.sv
  - target: simulation
    files:
      - sim/mem_subsys_assert.sv
      - sim/mem_subsys_tb.sv
